//--- design/usb_tx_pkg.sv
/*
 * Shared types and constants for the USB low-level packet transmitter
 * Byte and CRC types, byte source and line state enums, protocol constants
 */

package usb_tx_pkg;

	typedef logic [7:0] usb_byte_t;
	typedef logic [15:0] usb_crc_t;

	// Byte source for the shifter
	typedef enum logic [1:0] {
		SEL_SYNC,
		SEL_DATA,
		SEL_CRC_LO,
		SEL_CRC_HI
	} byte_sel_t;

	// Differential pair state
	typedef enum logic [1:0] {
		LINE_J,
		LINE_K,
		LINE_SE0
	} line_state_t;

	// KJKJKJKK on the line, LSB first
	localparam usb_byte_t SYNC_BYTE = 8'h80;
	localparam usb_crc_t CRC_INIT = 16'hFFFF;
	localparam usb_crc_t CRC_POLY_REFL = 16'hA001;
	localparam logic [2:0] STUFF_RUN = 3'd6;

endpackage

//--- design/usb_tx_buffer.sv
/*
 * Circular payload byte buffer with last flags
 * Forms pkt_ready and returns one credit per byte popped
 */

`timescale 1ns/10ps

module usb_tx_buffer #(
	parameter int DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  n_rst,
	input  logic                  wr_valid,
	input  usb_tx_pkg::usb_byte_t wr_data,
	input  logic                  wr_last,
	input  logic                  rd_en,
	output usb_tx_pkg::usb_byte_t head_data,
	output logic                  head_last,
	output logic                  pkt_ready,
	output logic                  credit_return
);
	localparam int AW = $clog2(DEPTH);

	usb_tx_pkg::usb_byte_t mem [DEPTH];
	logic last_mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic [AW:0] last_cnt;
	logic full;
	logic empty;

	assign full = (count == (AW+1)'(DEPTH));
	assign empty = (count == '0);
	assign head_last = last_mem[rd_ptr];
	// A whole packet, or as much of it as fits
	assign pkt_ready = (last_cnt != '0) || full;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			last_cnt <= '0;
			credit_return <= 1'b0;
		end else begin
			if (wr_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (AW+1)'(wr_valid) - (AW+1)'(rd_en);
			last_cnt <= last_cnt + (AW+1)'(wr_valid && wr_last) - (AW+1)'(rd_en && head_last);
			credit_return <= rd_en;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_valid) begin
			mem[wr_ptr] <= wr_data;
			last_mem[wr_ptr] <= wr_last;
		end
		if (rd_en)
			head_data <= mem[rd_ptr];
	end

	// Upstream spends only credits it holds
	assert property (@(posedge clk) disable iff (!n_rst) wr_valid |-> !full)
		else $error("write into full buffer");

	// Upstream kept pace with returned credits
	assert property (@(posedge clk) disable iff (!n_rst) rd_en |-> !empty)
		else $error("pop from empty buffer");

endmodule

//--- design/usb_tx_controller.sv
/*
 * Packet sequencing FSM for the transmitter
 * Orders SYNC, payload, CRC16 and end-of-packet, one byte load per byte_sent
 */

`timescale 1ns/10ps

module usb_tx_controller (
	input  logic                  clk,
	input  logic                  n_rst,
	input  logic                  pkt_ready,
	input  logic                  head_last,
	input  logic                  byte_sent,
	input  logic                  eop_done,
	output logic                  rd_en,
	output logic                  load,
	output usb_tx_pkg::byte_sel_t sel,
	output logic                  shift_en,
	output logic                  crc_clear,
	output logic                  crc_enable,
	output logic                  create_eop,
	output logic                  transmitting
);
	typedef enum logic [3:0] {
		IDLE, LOAD_SYNC, TX_SYNC, READ, LOAD, TX_DATA,
		LOAD_CRC_LO, TX_CRC_LO, LOAD_CRC_HI, TX_CRC_HI,
		CREATE_EOP, WAIT_EOP
	} state_t;

	state_t state;
	state_t next_state;
	logic last_q;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= IDLE;
			last_q <= 1'b0;
			crc_enable <= 1'b0;
		end else begin
			state <= next_state;
			if (state == IDLE) begin
				last_q <= 1'b0;
				crc_enable <= 1'b0;
			end
			if (rd_en)
				last_q <= head_last;
			// CRC covers payload bytes only
			if (load)
				crc_enable <= (sel == usb_tx_pkg::SEL_DATA);
		end
	end

	// LOAD states wait for the previous byte to finish so the line never stalls
	always_comb begin
		next_state = state;
		rd_en = 1'b0;
		load = 1'b0;
		sel = usb_tx_pkg::SEL_SYNC;
		shift_en = 1'b1;
		crc_clear = 1'b0;
		create_eop = 1'b0;
		transmitting = 1'b1;
		case (state)
			IDLE: begin
				shift_en = 1'b0;
				transmitting = 1'b0;
				crc_clear = 1'b1;
				if (pkt_ready)
					next_state = LOAD_SYNC;
			end
			LOAD_SYNC: begin
				load = 1'b1;
				next_state = TX_SYNC;
			end
			TX_SYNC: next_state = READ;
			READ: begin
				rd_en = 1'b1;
				next_state = LOAD;
			end
			LOAD: begin
				sel = usb_tx_pkg::SEL_DATA;
				if (byte_sent) begin
					load = 1'b1;
					next_state = TX_DATA;
				end
			end
			TX_DATA: next_state = last_q ? LOAD_CRC_LO : READ;
			LOAD_CRC_LO: begin
				sel = usb_tx_pkg::SEL_CRC_LO;
				if (byte_sent) begin
					load = 1'b1;
					next_state = TX_CRC_LO;
				end
			end
			TX_CRC_LO: next_state = LOAD_CRC_HI;
			LOAD_CRC_HI: begin
				sel = usb_tx_pkg::SEL_CRC_HI;
				if (byte_sent) begin
					load = 1'b1;
					next_state = TX_CRC_HI;
				end
			end
			TX_CRC_HI: begin
				if (byte_sent)
					next_state = CREATE_EOP;
			end
			CREATE_EOP: begin
				shift_en = 1'b0;
				create_eop = 1'b1;
				next_state = WAIT_EOP;
			end
			WAIT_EOP: begin
				shift_en = 1'b0;
				if (eop_done)
					next_state = IDLE;
			end
			default: next_state = IDLE;
		endcase
	end

	// Shifter ends a byte only while the FSM waits for one
	assert property (@(posedge clk) disable iff (!n_rst)
		byte_sent |-> state inside {LOAD, LOAD_CRC_LO, LOAD_CRC_HI, TX_CRC_HI})
		else $error("byte finished while no byte was awaited");

	// End-of-packet completes only while the FSM waits for it
	assert property (@(posedge clk) disable iff (!n_rst) eop_done |-> state == WAIT_EOP)
		else $error("eop_done outside WAIT_EOP");

endmodule

//--- design/usb_tx_shifter.sv
/*
 * Byte shifter, LSB first, with bit stuffing
 * Selects SYNC, payload or CRC bytes and flags data and line bits
 */

`timescale 1ns/10ps

module usb_tx_shifter (
	input  logic                  clk,
	input  logic                  n_rst,
	input  logic                  load,
	input  usb_tx_pkg::byte_sel_t sel,
	input  logic                  shift_en,
	input  usb_tx_pkg::usb_byte_t head_data,
	input  usb_tx_pkg::usb_crc_t  crc_out,
	input  logic                  transmitting,
	output logic                  data_bit,
	output logic                  bit_strobe,
	output logic                  line_bit_valid,
	output logic                  byte_sent
);
	usb_tx_pkg::byte_sel_t sel_q;
	usb_tx_pkg::usb_byte_t data_q;
	usb_tx_pkg::usb_byte_t cur_byte;
	logic active;
	logic tail_q;
	logic [2:0] bit_cnt;
	logic [2:0] run_cnt;
	logic stuff;
	logic next_stuff;

	// CRC halves read live, the remainder settles with the final data bit
	always_comb begin
		case (sel_q)
			usb_tx_pkg::SEL_SYNC:   cur_byte = usb_tx_pkg::SYNC_BYTE;
			usb_tx_pkg::SEL_DATA:   cur_byte = data_q;
			usb_tx_pkg::SEL_CRC_LO: cur_byte = crc_out[7:0];
			default:                cur_byte = crc_out[15:8];
		endcase
	end

	assign stuff = (run_cnt == usb_tx_pkg::STUFF_RUN);
	assign line_bit_valid = active && shift_en;
	assign data_bit = stuff ? 1'b0 : cur_byte[bit_cnt];
	assign bit_strobe = line_bit_valid && !stuff;
	assign next_stuff = data_bit && (run_cnt == usb_tx_pkg::STUFF_RUN - 3'd1);
	// A stuffed bit right after bit 7 still belongs to this byte
	assign byte_sent = line_bit_valid && (stuff ? tail_q : (bit_cnt == 3'd7 && !next_stuff));

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			active <= 1'b0;
			tail_q <= 1'b0;
			bit_cnt <= 3'd0;
			run_cnt <= 3'd0;
			sel_q <= usb_tx_pkg::SEL_SYNC;
		end else if (!transmitting) begin
			active <= 1'b0;
			tail_q <= 1'b0;
			bit_cnt <= 3'd0;
			run_cnt <= 3'd0;
		end else begin
			if (line_bit_valid) begin
				if (stuff) begin
					run_cnt <= 3'd0;
					tail_q <= 1'b0;
				end else begin
					run_cnt <= data_bit ? run_cnt + 3'd1 : 3'd0;
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7)
						tail_q <= next_stuff;
				end
				if (byte_sent)
					active <= 1'b0;
			end
			if (load) begin
				active <= 1'b1;
				bit_cnt <= 3'd0;
				sel_q <= sel;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load && sel == usb_tx_pkg::SEL_DATA)
			data_q <= head_data;
	end

endmodule

//--- design/usb_crc16.sv
/*
 * Bit-serial reflected USB CRC16 over payload bits
 * Gives out the complemented remainder
 */

`timescale 1ns/10ps

module usb_crc16 (
	input  logic                 clk,
	input  logic                 n_rst,
	input  logic                 crc_clear,
	input  logic                 crc_enable,
	input  logic                 bit_strobe,
	input  logic                 data_bit,
	output usb_tx_pkg::usb_crc_t crc_out
);
	usb_tx_pkg::usb_crc_t crc_q;
	logic feedback;

	assign feedback = crc_q[0] ^ data_bit;

	// Stuffed bits never reach the remainder
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			crc_q <= usb_tx_pkg::CRC_INIT;
		end else if (crc_clear) begin
			crc_q <= usb_tx_pkg::CRC_INIT;
		end else if (crc_enable && bit_strobe) begin
			if (feedback)
				crc_q <= (crc_q >> 1) ^ usb_tx_pkg::CRC_POLY_REFL;
			else
				crc_q <= crc_q >> 1;
		end
	end

	assign crc_out = ~crc_q;

endmodule

//--- design/usb_line_encoder.sv
/*
 * NRZI line encoder with end-of-packet sequencing
 * Drives the dp/dm pair from a J, K or SE0 line state
 */

`timescale 1ns/10ps

module usb_line_encoder (
	input  logic clk,
	input  logic n_rst,
	input  logic data_bit,
	input  logic line_bit_valid,
	input  logic create_eop,
	output logic dp,
	output logic dm,
	output logic eop_done
);
	usb_tx_pkg::line_state_t line_q;
	logic [1:0] eop_cnt;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			line_q <= usb_tx_pkg::LINE_J;
			eop_cnt <= 2'd0;
			eop_done <= 1'b0;
		end else begin
			eop_done <= 1'b0;
			if (create_eop) begin
				line_q <= usb_tx_pkg::LINE_SE0;
				eop_cnt <= 2'd1;
			end else if (eop_cnt == 2'd1) begin
				eop_cnt <= 2'd2;
			end else if (eop_cnt == 2'd2) begin
				// One J bit time closes the EOP
				line_q <= usb_tx_pkg::LINE_J;
				eop_cnt <= 2'd0;
				eop_done <= 1'b1;
			end else if (line_bit_valid && !data_bit) begin
				line_q <= (line_q == usb_tx_pkg::LINE_J) ? usb_tx_pkg::LINE_K : usb_tx_pkg::LINE_J;
			end
		end
	end

	assign dp = (line_q == usb_tx_pkg::LINE_J);
	assign dm = (line_q == usb_tx_pkg::LINE_K);

	// EOP only once the shifter has drained, including a trailing stuffed bit
	assert property (@(posedge clk) disable iff (!n_rst) create_eop |-> !line_bit_valid)
		else $error("EOP requested while bits still on the line");

endmodule

//--- design/usb_tx_top.sv
/*
 * USB low-level packet transmitter top level
 * Buffer, controller, shifter, CRC16 and line encoder
 */

`timescale 1ns/10ps

module usb_tx_top #(
	parameter int DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  n_rst,
	input  logic                  wr_valid,
	input  usb_tx_pkg::usb_byte_t wr_data,
	input  logic                  wr_last,
	output logic                  credit_return,
	output logic                  dp,
	output logic                  dm,
	output logic                  tx_active
);
	usb_tx_pkg::usb_byte_t head_data;
	usb_tx_pkg::byte_sel_t sel;
	usb_tx_pkg::usb_crc_t crc_out;
	logic pkt_ready;
	logic head_last;
	logic rd_en;
	logic load;
	logic shift_en;
	logic byte_sent;
	logic data_bit;
	logic bit_strobe;
	logic line_bit_valid;
	logic crc_clear;
	logic crc_enable;
	logic create_eop;
	logic eop_done;

	usb_tx_buffer #(.DEPTH(DEPTH)) i_usb_tx_buffer (
		.clk, .n_rst, .wr_valid, .wr_data, .wr_last, .rd_en,
		.head_data, .head_last, .pkt_ready, .credit_return
	);

	usb_tx_controller i_usb_tx_controller (
		.clk, .n_rst, .pkt_ready, .head_last, .byte_sent, .eop_done,
		.rd_en, .load, .sel, .shift_en, .crc_clear, .crc_enable, .create_eop,
		.transmitting(tx_active)
	);

	usb_tx_shifter i_usb_tx_shifter (
		.clk, .n_rst, .load, .sel, .shift_en, .head_data, .crc_out,
		.transmitting(tx_active), .data_bit, .bit_strobe, .line_bit_valid, .byte_sent
	);

	usb_crc16 i_usb_crc16 (
		.clk, .n_rst, .crc_clear, .crc_enable, .bit_strobe, .data_bit, .crc_out
	);

	usb_line_encoder i_usb_line_encoder (
		.clk, .n_rst, .data_bit, .line_bit_valid, .create_eop, .dp, .dm, .eop_done
	);

endmodule

//--- tests/tb_usb_tx.sv
/*
 * Trace-driven testbench for the USB packet transmitter
 * Credit-based byte feeder, NRZI line decoder with unstuffing, CRC16 reference
 */

`timescale 1ns/10ps

module tb_usb_tx;

	localparam int CLK_PERIOD = 100;

	logic clk;
	logic n_rst;
	logic wr_valid;
	usb_tx_pkg::usb_byte_t wr_data;
	logic wr_last;
	logic credit_return;
	logic dp;
	logic dm;
	logic tx_active;

	logic [15:0] trace_mem [0:255];
	usb_tx_pkg::usb_byte_t exp_data[$];
	usb_tx_pkg::usb_crc_t pkt_crc[$];
	int pkt_len[$];
	int pkt_start[$];
	usb_tx_pkg::usb_byte_t rx_bytes[$];
	usb_tx_pkg::usb_byte_t cur_byte;
	usb_tx_pkg::line_state_t prev_line;
	int depth;
	int written = 0;
	int returned = 0;
	int pkts_seen = 0;
	int value_errs = 0;
	int other_errs = 0;
	int ones;
	int nbits;
	int eop_idx;
	logic pkt_open = 1'b0;
	logic started;
	logic closed;
	logic trace_loaded = 1'b0;

	usb_tx_top i_usb_tx_top (
		.clk, .n_rst, .wr_valid, .wr_data, .wr_last,
		.credit_return, .dp, .dm, .tx_active
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic compare_byte(input usb_tx_pkg::usb_byte_t got,
			input usb_tx_pkg::usb_byte_t exp, input string what);
		if (got !== exp) begin
			value_errs++;
			$display("ERR %0t: %s byte %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic compare_crc(input usb_tx_pkg::usb_crc_t got,
			input usb_tx_pkg::usb_crc_t exp, input string what);
		if (got !== exp) begin
			value_errs++;
			$display("ERR %0t: %s CRC16 %04h, expected %04h", $time, what, got, exp);
		end
	endtask

	task automatic compare_line(input usb_tx_pkg::line_state_t got,
			input usb_tx_pkg::line_state_t exp, input string what);
		if (got !== exp) begin
			value_errs++;
			$display("ERR %0t: %s line state %s (%0d), expected %s", $time, what,
				got.name(), got, exp.name());
		end
	endtask

	function automatic usb_tx_pkg::line_state_t line_now();
		if (dp && !dm)
			return usb_tx_pkg::LINE_J;
		if (!dp && dm)
			return usb_tx_pkg::LINE_K;
		if (!dp && !dm)
			return usb_tx_pkg::LINE_SE0;
		return usb_tx_pkg::line_state_t'(2'b11);
	endfunction

	// Reflected CRC16, LSB first over the payload, complemented at the end
	function automatic usb_tx_pkg::usb_crc_t calc_crc(input int base, input int len);
		usb_tx_pkg::usb_crc_t crc;
		usb_tx_pkg::usb_byte_t b;
		int i;
		int k;
		crc = usb_tx_pkg::CRC_INIT;
		for (i = 0; i < len; i++) begin
			b = exp_data[base + i];
			for (k = 0; k < 8; k++) begin
				if (crc[0] ^ b[k])
					crc = (crc >> 1) ^ usb_tx_pkg::CRC_POLY_REFL;
				else
					crc = crc >> 1;
			end
		end
		return ~crc;
	endfunction

	task automatic load_trace();
		int idx;
		int n;
		int i;
		$readmemh("tests/usb_tx_trace.txt", trace_mem);
		idx = 0;
		while (idx < 256 && !$isunknown(trace_mem[idx]) && trace_mem[idx] != 16'h0) begin
			n = int'(trace_mem[idx]);
			pkt_start.push_back(exp_data.size());
			pkt_len.push_back(n);
			for (i = 0; i < n; i++)
				exp_data.push_back(usb_tx_pkg::usb_byte_t'(trace_mem[idx + 1 + i]));
			pkt_crc.push_back(trace_mem[idx + 1 + n]);
			compare_crc(calc_crc(pkt_start[$], n), pkt_crc[$], "trace reference");
			idx += n + 2;
		end
		if (pkt_len.size() == 0) begin
			other_errs++;
			$display("No packets could be read from tests/usb_tx_trace.txt");
		end
		trace_loaded = 1'b1;
	endtask

	task automatic write_byte(input usb_tx_pkg::usb_byte_t b, input logic last);
		@(negedge clk);
		while (written - returned >= depth) begin
			wr_valid = 1'b0;
			@(negedge clk);
		end
		wr_valid = 1'b1;
		wr_data = b;
		wr_last = last;
		written++;
	endtask

	task automatic take_bit(input logic b);
		// A bit after a full run of ones is the stuffed zero
		if (ones == int'(usb_tx_pkg::STUFF_RUN)) begin
			if (b) begin
				other_errs++;
				$display("Seven consecutive ones on the line at %0t", $time);
			end
			ones = 0;
		end else begin
			ones = b ? ones + 1 : 0;
			cur_byte[nbits] = b;
			nbits++;
			if (nbits == 8) begin
				rx_bytes.push_back(cur_byte);
				nbits = 0;
			end
		end
	endtask

	task automatic check_packet();
		int len;
		int base;
		int i;
		if (pkts_seen >= pkt_len.size()) begin
			other_errs++;
			$display("Packet received beyond the end of the trace at %0t", $time);
			return;
		end
		len = pkt_len[pkts_seen];
		base = pkt_start[pkts_seen];
		if (nbits != 0 || rx_bytes.size() != len + 3) begin
			other_errs++;
			$display("Packet %0d decoded to %0d bytes and %0d spare bits, expected %0d bytes",
				pkts_seen, rx_bytes.size(), nbits, len + 3);
		end else begin
			compare_byte(rx_bytes[0], usb_tx_pkg::SYNC_BYTE, "sync");
			for (i = 0; i < len; i++)
				compare_byte(rx_bytes[i + 1], exp_data[base + i], "payload");
			compare_crc({rx_bytes[len + 2], rx_bytes[len + 1]}, pkt_crc[pkts_seen], "line");
		end
		pkts_seen++;
	endtask

	always @(posedge clk) begin
		if (n_rst) begin
			if (credit_return)
				returned++;
			if (written - returned > depth || returned > written) begin
				other_errs++;
				$display("Credit count broken at %0t: %0d written, %0d returned",
					$time, written, returned);
			end
		end
	end

	// Line decoder, sampling the pair while tx_active is high
	always @(posedge clk) begin : monitor
		usb_tx_pkg::line_state_t ls;
		if (n_rst) begin
			ls = line_now();
			if (tx_active) begin
				if (!pkt_open) begin
					pkt_open = 1'b1;
					started = 1'b0;
					closed = 1'b0;
					prev_line = usb_tx_pkg::LINE_J;
					ones = 0;
					nbits = 0;
					eop_idx = 0;
					rx_bytes.delete();
				end
				if (closed) begin
					other_errs++;
					$display("tx_active still high after the end-of-packet J at %0t", $time);
				end else if (eop_idx > 0 || ls == usb_tx_pkg::LINE_SE0) begin
					compare_line(ls, (eop_idx < 2) ? usb_tx_pkg::LINE_SE0 : usb_tx_pkg::LINE_J,
						"end-of-packet");
					eop_idx++;
					if (eop_idx == 3) begin
						closed = 1'b1;
						check_packet();
					end
				end else if (started || ls == usb_tx_pkg::LINE_K) begin
					// First K marks the first SYNC bit
					started = 1'b1;
					take_bit(ls == prev_line);
					prev_line = ls;
				end
			end else if (pkt_open) begin
				pkt_open = 1'b0;
				if (!closed) begin
					other_errs++;
					$display("tx_active fell before the end-of-packet finished at %0t", $time);
				end
			end
		end
	end

	initial begin
		int p;
		int i;
		int gap;
		void'($urandom(54));
		depth = i_usb_tx_top.DEPTH;
		n_rst = 1'b0;
		wr_valid = 1'b0;
		wr_data = '0;
		wr_last = 1'b0;
		load_trace();
		repeat (2) @(negedge clk);
		n_rst = 1'b1;
		@(negedge clk);
		compare_line(line_now(), usb_tx_pkg::LINE_J, "after reset");
		if (tx_active || credit_return) begin
			other_errs++;
			$display("tx_active or credit_return high right after reset");
		end
		for (p = 0; p < pkt_len.size(); p++) begin
			gap = $urandom % 4;
			for (i = 0; i < gap; i++) begin
				@(negedge clk);
				wr_valid = 1'b0;
			end
			for (i = 0; i < pkt_len[p]; i++)
				write_byte(exp_data[pkt_start[p] + i], i == pkt_len[p] - 1);
		end
		@(negedge clk);
		wr_valid = 1'b0;
		wait (pkts_seen == pkt_len.size());
		repeat (4) @(negedge clk);
		compare_line(line_now(), usb_tx_pkg::LINE_J, "idle at end");
		if (returned != written) begin
			other_errs++;
			$display("%0d bytes written but %0d credits returned", written, returned);
		end
		$display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// Watchdog sized from the trace length
	initial begin
		wait (trace_loaded);
		#((40 * exp_data.size() + 200) * CLK_PERIOD);
		$display("Timeout: %0d of %0d packets received before the time limit",
			pkts_seen, pkt_len.size());
		$display("Test failed");
		$finish;
	end

endmodule

//--- tests/usb_tx_trace.txt
// Per line: payload byte count, payload bytes, expected CRC16 (all hex)
// CRC16 is sent low byte first; a count of 0 ends the trace
1 FF FF00
2 FF FF FFFF
3 FF FF FF BFBF
4 FF FF FF FF 4FFE
// ASCII 123456789, the standard check string
9 31 32 33 34 35 36 37 38 39 B4C8
6 01 03 00 00 00 0A 323A
6 11 03 00 6B 00 03 7889
6 01 03 00 00 00 01 F57B
0

//--- flist.f
design/usb_tx_pkg.sv
design/usb_tx_buffer.sv
design/usb_tx_controller.sv
design/usb_tx_shifter.sv
design/usb_crc16.sv
design/usb_line_encoder.sv
design/usb_tx_top.sv
tests/tb_usb_tx.sv

//--- Bender.yml
package:
  name: usb_tx

sources:
  - design/usb_tx_pkg.sv
  - design/usb_tx_buffer.sv
  - design/usb_tx_controller.sv
  - design/usb_tx_shifter.sv
  - design/usb_crc16.sv
  - design/usb_line_encoder.sv
  - design/usb_tx_top.sv
  - target: test
    files:
      - tests/tb_usb_tx.sv
